// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_merge_tree
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== logic/channel_fifo.sv ====
/*
  Multi-channel record FIFO, 2**CH_LOG channels of 2**FIFO_LOG entries each.
  All channels share one memory; the channel number forms the upper address bits.
  Read data is registered, so o_rec shows the head of i_deq_ch one cycle later.
*/
`timescale 1ns/1ps
`default_nettype none

module channel_fifo #(
  parameter int CH_LOG   = 1,
  parameter int FIFO_LOG = 2
) (
  input  wire                     CLK,
  input  wire                     RST,
  input  wire                     i_enq,
  input  wire [CH_LOG-1:0]        i_enq_ch,
  input  wire                     i_deq,
  input  wire [CH_LOG-1:0]        i_deq_ch,
  input  msort_pkg::rec_t         i_rec,
  output msort_pkg::rec_t         o_rec,
  output logic [(2**CH_LOG)-1:0]  o_empty,
  output logic [(2**CH_LOG)-1:0]  o_full
);
  import msort_pkg::*;

  localparam int NCH = 2**CH_LOG;

  rec_t              mem [2**(CH_LOG+FIFO_LOG)];
  logic [FIFO_LOG:0] head [NCH]; // one wrap bit above the slot index
  logic [FIFO_LOG:0] tail [NCH];

  logic [CH_LOG+FIFO_LOG-1:0] raddr;
  logic [CH_LOG+FIFO_LOG-1:0] waddr;

  for (genvar c = 0; c < NCH; c++) begin : g_flags
    assign o_empty[c] = (head[c] == tail[c]);
    assign o_full[c]  = (head[c] == {~tail[c][FIFO_LOG], tail[c][FIFO_LOG-1:0]});
  end

  assign raddr = {i_deq_ch, head[i_deq_ch][FIFO_LOG-1:0]};
  assign waddr = {i_enq_ch, tail[i_enq_ch][FIFO_LOG-1:0]};

  always_ff @(posedge CLK) begin
    if (RST) begin
      for (int c = 0; c < NCH; c++) begin
        head[c] <= '0;
        tail[c] <= '0;
      end
    end else begin
      if (i_enq) tail[i_enq_ch] <= tail[i_enq_ch] + 1'b1;
      if (i_deq) head[i_deq_ch] <= head[i_deq_ch] + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (i_enq) mem[waddr] <= i_rec;
    o_rec <= mem[raddr]; // registered read
  end

  a_no_overflow: assert property (@(posedge CLK) disable iff (RST)
    !(i_enq && o_full[i_enq_ch])) else $error("channel_fifo overflow");
  a_no_underflow: assert property (@(posedge CLK) disable iff (RST)
    !(i_deq && o_empty[i_deq_ch])) else $error("channel_fifo underflow");

endmodule

`default_nettype wire

// ==== logic/merge_stage_body.sv ====
/*
  Non-root merge stage serving 2**(STAGE_LOG-1) channel pairs.
  Records from the upper stage land in the even or odd channel FIFO by the
  low index bit. The parent's queued request picks a pair; the smaller head
  goes down tagged with the pair index. Fires at most once every two cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module merge_stage_body #(
  parameter int STAGE_LOG = 2, // width of the incoming record index
  parameter int FIFO_LOG  = 2
) (
  input  wire                    CLK,
  input  wire                    RST,
  input  wire                    i_q_full,
  input  wire [STAGE_LOG-2:0]    i_req_idx,
  input  wire                    i_req_valid,
  input  msort_pkg::rec_t        i_rec,
  input  wire                    i_rec_valid,
  input  wire [STAGE_LOG-1:0]    i_rec_idx,
  output logic                   o_q_full,
  output logic [STAGE_LOG-1:0]   o_req_idx,
  output logic                   o_req_valid,
  output msort_pkg::rec_t        o_rec,
  output logic                   o_valid,
  output logic [STAGE_LOG-2:0]   o_rec_idx
);
  import msort_pkg::*;

  localparam int CH_LOG = STAGE_LOG - 1;

  logic [CH_LOG-1:0]      q_idx; // pair selected by the parent
  logic                   q_empty;
  logic                   fire;
  logic                   take_even;
  rec_t                   even_rec, odd_rec;
  logic [(2**CH_LOG)-1:0] even_empty, odd_empty;
  logic                   emp0, emp1;
  logic [STAGE_LOG-1:0]   req_for_empty;
  stage_state_e           fire_st, req_st;

  request_queue #(.IDX_W(CH_LOG)) u_req_q (
    .CLK(CLK), .RST(RST),
    .i_enq(i_req_valid), .i_deq(fire), .i_idx(i_req_idx),
    .o_idx(q_idx), .o_empty(q_empty), .o_full(o_q_full)
  );

  channel_fifo #(.CH_LOG(CH_LOG), .FIFO_LOG(FIFO_LOG)) u_even (
    .CLK(CLK), .RST(RST),
    .i_enq(i_rec_valid & ~i_rec_idx[0]), .i_enq_ch(i_rec_idx[STAGE_LOG-1:1]),
    .i_deq(fire & take_even), .i_deq_ch(q_idx), .i_rec(i_rec),
    .o_rec(even_rec), .o_empty(even_empty), .o_full()
  );

  channel_fifo #(.CH_LOG(CH_LOG), .FIFO_LOG(FIFO_LOG)) u_odd (
    .CLK(CLK), .RST(RST),
    .i_enq(i_rec_valid & i_rec_idx[0]), .i_enq_ch(i_rec_idx[STAGE_LOG-1:1]),
    .i_deq(fire & ~take_even), .i_deq_ch(q_idx), .i_rec(i_rec),
    .o_rec(odd_rec), .o_empty(odd_empty), .o_full()
  );

  assign emp0      = even_empty[q_idx];
  assign emp1      = odd_empty[q_idx];
  assign fire      = (fire_st == ST_FIRE);
  assign take_even = key_less(even_rec, odd_rec); // tie goes to odd

  // remember which child of the current pair ran dry
  always_ff @(posedge CLK) begin
    if (RST) req_for_empty <= '0;
    else if (emp0) req_for_empty <= {q_idx, 1'b0};
    else if (emp1) req_for_empty <= {q_idx, 1'b1};
  end

  // fire machine, idle cycle lets the registered read settle
  always_ff @(posedge CLK) begin
    if (RST) fire_st <= ST_IDLE;
    else begin
      case (fire_st)
        ST_IDLE: if (!(i_q_full || q_empty || emp0 || emp1)) fire_st <= ST_FIRE;
        default: fire_st <= ST_IDLE;
      endcase
    end
  end

  // request machine, one pulse per two cycles
  always_ff @(posedge CLK) begin
    if (RST) req_st <= ST_IDLE;
    else begin
      case (req_st)
        ST_IDLE: if (!(i_q_full || q_empty)) req_st <= ST_FIRE;
        default: req_st <= ST_IDLE;
      endcase
    end
  end

  // refill the child just consumed, else the one seen empty
  assign o_req_idx   = fire ? {q_idx, ~take_even} : req_for_empty;
  assign o_req_valid = (req_st == ST_FIRE);
  assign o_rec       = take_even ? even_rec : odd_rec;
  assign o_valid     = fire;
  assign o_rec_idx   = q_idx;

endmodule

`default_nettype wire

// ==== logic/merge_stage_root.sv ====
/*
  Final two-way merge of the tree.
  Holds one record FIFO per side and emits the smaller head whenever both
  sides have data and the output is not full. Output is combinational.
*/
`timescale 1ns/1ps
`default_nettype none

module merge_stage_root #(
  parameter int FIFO_LOG = 2
) (
  input  wire              CLK,
  input  wire              RST,
  input  msort_pkg::rec_t  i_rec,
  input  wire              i_rec_valid,
  input  wire              i_src,
  input  wire              i_q_full,
  input  wire              i_out_full,
  output logic             o_req,
  output logic             o_req_valid,
  output msort_pkg::rec_t  o_rec,
  output logic             o_valid
);
  import msort_pkg::*;

  rec_t head0, head1;
  logic emp0, emp1;
  logic fire;
  logic take0;

  record_fifo #(.FIFO_LOG(FIFO_LOG)) u_side0 (
    .CLK(CLK), .RST(RST),
    .i_enq(i_rec_valid & ~i_src), .i_deq(fire & take0), .i_rec(i_rec),
    .o_rec(head0), .o_empty(emp0), .o_full()
  );

  record_fifo #(.FIFO_LOG(FIFO_LOG)) u_side1 (
    .CLK(CLK), .RST(RST),
    .i_enq(i_rec_valid & i_src), .i_deq(fire & ~take0), .i_rec(i_rec),
    .o_rec(head1), .o_empty(emp1), .o_full()
  );

  assign fire  = !(i_out_full || emp0 || emp1);
  assign take0 = key_less(head0, head1); // equal keys take side 1

  assign o_rec       = take0 ? head0 : head1;
  assign o_valid     = fire;
  assign o_req       = fire ? ~take0 : ~emp0; // side just drained, else refill
  assign o_req_valid = !(i_q_full || i_out_full);

endmodule

`default_nettype wire

// ==== logic/merge_tree.sv ====
/*
  Top level of the streaming merge-sorter tree with 2**W_LOG leaves.
  Stage 0 is the root; stages 1..W_LOG-1 are body stages. The outermost
  stage takes leaf records and issues leaf requests, the root drives o_rec.
*/
`timescale 1ns/1ps
`default_nettype none

module merge_tree #(
  parameter int W_LOG    = 2,
  parameter int FIFO_LOG = 2
) (
  input  wire              CLK,
  input  wire              RST,
  input  msort_pkg::rec_t  i_rec,
  input  wire              i_rec_valid,
  input  wire [W_LOG-1:0]  i_rec_idx,
  input  wire              i_req_full,
  input  wire              i_out_full,
  output logic [W_LOG-1:0] o_req_idx,
  output logic             o_req_valid,
  output msort_pkg::rec_t  o_rec,
  output logic             o_valid
);
  import msort_pkg::*;

  // entry k is what stage k sees or sends; indices zero-extended to W_LOG
  wire rec_t             lnk_rec   [W_LOG];
  wire [W_LOG-1:0]       lnk_valid;
  wire [W_LOG-1:0]       lnk_idx   [W_LOG];
  wire [W_LOG-1:0]       req_idx   [W_LOG];
  wire [W_LOG-1:0]       req_valid;
  wire [W_LOG-1:0]       q_full;   // queue-full seen by stage k

  // outermost stage talks to the leaves
  assign lnk_rec[W_LOG-1]   = i_rec;
  assign lnk_valid[W_LOG-1] = i_rec_valid;
  assign lnk_idx[W_LOG-1]   = i_rec_idx;
  assign q_full[W_LOG-1]    = i_req_full;
  assign o_req_idx          = req_idx[W_LOG-1];
  assign o_req_valid        = req_valid[W_LOG-1];

  for (genvar k = 0; k < W_LOG; k++) begin : g_stage
    if (k == 0) begin : g_root
      wire root_req;
      merge_stage_root #(.FIFO_LOG(FIFO_LOG)) u_root (
        .CLK(CLK), .RST(RST),
        .i_rec(lnk_rec[0]), .i_rec_valid(lnk_valid[0]), .i_src(lnk_idx[0][0]),
        .i_q_full(q_full[0]), .i_out_full(i_out_full),
        .o_req(root_req), .o_req_valid(req_valid[0]), .o_rec(o_rec), .o_valid(o_valid)
      );
      assign req_idx[0] = W_LOG'(root_req);
    end else begin : g_body
      wire [k:0]   req_k;
      wire [k-1:0] rec_idx_k;
      merge_stage_body #(.STAGE_LOG(k+1), .FIFO_LOG(FIFO_LOG)) u_body (
        .CLK(CLK), .RST(RST),
        .i_q_full(q_full[k]),
        .i_req_idx(req_idx[k-1][k-1:0]), .i_req_valid(req_valid[k-1]),
        .i_rec(lnk_rec[k]), .i_rec_valid(lnk_valid[k]), .i_rec_idx(lnk_idx[k][k:0]),
        .o_q_full(q_full[k-1]), .o_req_idx(req_k), .o_req_valid(req_valid[k]),
        .o_rec(lnk_rec[k-1]), .o_valid(lnk_valid[k-1]), .o_rec_idx(rec_idx_k)
      );
      assign req_idx[k]   = W_LOG'(req_k);
      assign lnk_idx[k-1] = W_LOG'(rec_idx_k);
    end
  end

endmodule

`default_nettype wire

// ==== logic/msort_pkg.sv ====
/*
  Shared types for the merge-sorter tree.
  Holds the record layout, the two-phase stage state and the key compare
  that every stage uses to pick the smaller head.
*/
`default_nettype none

package msort_pkg;

  localparam int KEY_W = 32; // sort key
  localparam int PAY_W = 32; // payload carried along with the key

  // key sits in the upper half, payload below it
  typedef struct packed {
    logic [KEY_W-1:0] key;
    logic [PAY_W-1:0] payload;
  } rec_t;

  // request and fire machines in the body stages toggle between these
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_FIRE = 1'b1
  } stage_state_e;

  // strict compare, so equal keys fall through to side 1
  function automatic logic key_less(rec_t a, rec_t b);
    return (a.key < b.key);
  endfunction

endpackage

`default_nettype wire

// ==== logic/record_fifo.sv ====
/*
  Single-channel circular record FIFO with 2**FIFO_LOG entries.
  The head record is visible combinationally on o_rec.
  Used twice by the root stage, one per side.
*/
`timescale 1ns/1ps
`default_nettype none

module record_fifo #(
  parameter int FIFO_LOG = 2
) (
  input  wire              CLK,
  input  wire              RST,
  input  wire              i_enq,
  input  wire              i_deq,
  input  msort_pkg::rec_t  i_rec,
  output msort_pkg::rec_t  o_rec,
  output logic             o_empty,
  output logic             o_full
);
  import msort_pkg::*;

  rec_t              mem [2**FIFO_LOG];
  logic [FIFO_LOG:0] head; // extra msb tells full from empty
  logic [FIFO_LOG:0] tail;

  assign o_empty = (head == tail);
  assign o_full  = (head == {~tail[FIFO_LOG], tail[FIFO_LOG-1:0]});
  assign o_rec   = mem[head[FIFO_LOG-1:0]];

  always_ff @(posedge CLK) begin
    if (RST) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (i_enq) tail <= tail + 1'b1;
      if (i_deq) head <= head + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (i_enq) mem[tail[FIFO_LOG-1:0]] <= i_rec;
  end

  a_no_overflow: assert property (@(posedge CLK) disable iff (RST) !(i_enq && o_full))
    else $error("record_fifo overflow");
  a_no_underflow: assert property (@(posedge CLK) disable iff (RST) !(i_deq && o_empty))
    else $error("record_fifo underflow");

endmodule

`default_nettype wire

// ==== logic/request_queue.sv ====
/*
  Two-entry queue of parent request indices inside a body stage.
  An entry stays until the stage fires for that channel pair.
*/
`timescale 1ns/1ps
`default_nettype none

module request_queue #(
  parameter int IDX_W = 1
) (
  input  wire              CLK,
  input  wire              RST,
  input  wire              i_enq,
  input  wire              i_deq,
  input  wire [IDX_W-1:0]  i_idx,
  output logic [IDX_W-1:0] o_idx,
  output logic             o_empty,
  output logic             o_full
);

  logic [IDX_W-1:0] mem [2];
  logic             head;
  logic             tail;
  logic [1:0]       cnt;

  assign o_empty = (cnt == 2'd0);
  assign o_full  = (cnt == 2'd2);
  assign o_idx   = mem[head];

  always_ff @(posedge CLK) begin
    if (RST) begin
      head <= 1'b0;
      tail <= 1'b0;
      cnt  <= 2'd0;
    end else begin
      if (i_enq) tail <= ~tail;
      if (i_deq) head <= ~head;
      case ({i_enq, i_deq})
        2'b10:   cnt <= cnt + 2'd1;
        2'b01:   cnt <= cnt - 2'd1;
        default: cnt <= cnt; // both or neither
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (i_enq) mem[tail] <= i_idx;
  end

  // parent only requests while o_full is low
  a_no_push_full: assert property (@(posedge CLK) disable iff (RST) !(i_enq && o_full))
    else $error("request_queue pushed while full");

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+testbench
logic/msort_pkg.sv
logic/record_fifo.sv
logic/channel_fifo.sv
logic/request_queue.sv
logic/merge_stage_body.sv
logic/merge_stage_root.sv
logic/merge_tree.sv
testbench/tb_merge_tree.sv

// ==== testbench/tb_tasks.svh ====
/*
  Directed tests, value check and expected-order computation.
  Included inside the testbench module body.
*/

task automatic fail_now(input string why);
  $display("%s", why);
  $display("Done: errors found");
  $fatal(1, "stopped at first error");
endtask

task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
  if (got !== exp) begin
    fail_now($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
  end
endtask

// payload carries leaf in the top byte and list position below
task automatic add_rec(input int leaf, input logic [31:0] key);
  leaf_mem[leaf][leaf_len[leaf]] = '{key: key, payload: {8'(leaf), 24'(leaf_len[leaf])}};
  leaf_len[leaf]++;
endtask

task automatic clear_leaves();
  for (int l = 0; l < NLEAF; l++) begin
    leaf_len[l] = 0;
    leaf_pos[l] = 0;
  end
endtask

function automatic rec_t next_leaf_rec(input int l);
  rec_t r;
  if (leaf_pos[l] < leaf_len[l]) begin
    r = leaf_mem[l][leaf_pos[l]];
    leaf_pos[l]++;
  end else begin
    r.key     = '1; // exhausted leaf, sorts last
    r.payload = 32'hee00_0000 | 32'(l);
  end
  return r;
endfunction

// smaller key first; equal keys go higher leaf first, then list order
function automatic logic goes_before(input rec_t a, input rec_t b);
  if (a.key != b.key) return a.key < b.key;
  if (a.payload[31:24] != b.payload[31:24]) return a.payload[31:24] > b.payload[31:24];
  return a.payload[23:0] < b.payload[23:0];
endfunction

task automatic build_expected();
  int i;
  exp_q.delete();
  for (int l = 0; l < NLEAF; l++) begin
    for (int p = 0; p < leaf_len[l]; p++) begin
      i = 0;
      while (i < exp_q.size() && !goes_before(leaf_mem[l][p], exp_q[i])) i++;
      exp_q.insert(i, leaf_mem[l][p]);
    end
  end
endtask

task automatic apply_reset();
  @(posedge CLK);
  RST         <= 1'b1;
  priming     <= 1'b1;
  i_req_full  <= 1'b1; // no leaf requests until priming is done
  i_out_full  <= 1'b0;
  i_rec_valid <= 1'b0;
  repeat (3) @(posedge CLK);
  for (int l = 0; l < NLEAF; l++) leaf_pos[l] = 0; // lists restart from the top
  RST <= 1'b0;
endtask

task automatic prime_leaves();
  for (int l = 0; l < NLEAF; l++) begin
    for (int d = 0; d < DEPTH; d++) begin
      @(posedge CLK);
      i_rec       <= next_leaf_rec(l);
      i_rec_valid <= 1'b1;
      i_rec_idx   <= W_LOG'(l);
    end
  end
  @(posedge CLK);
  i_rec_valid <= 1'b0;
  i_req_full  <= 1'b0;
  priming     <= 1'b0; // leaf model takes over next edge
endtask

task automatic run_merge(input int stall_at, input int stall_len);
  int n;
  bit stalled;
  stalled = 1'b0;
  apply_reset();
  build_expected();
  n         = exp_q.size();
  out_cnt   = 0;
  cyc       = 0;
  cyc_limit = 40 * n + 200 + stall_len;
  prime_leaves();
  while (out_cnt < n) begin
    @(posedge CLK);
    if (stall_at >= 0 && !stalled && out_cnt >= stall_at) begin
      i_out_full <= 1'b1;
      repeat (stall_len) @(posedge CLK);
      i_out_full <= 1'b0;
      stalled = 1'b1;
    end
  end
  repeat (16) @(posedge CLK); // room for a duplicate to appear
  @(negedge CLK);
  check_equal(64'(out_cnt), 64'(n), "record count");
  cyc       = 0;
  cyc_limit = 200;
endtask

task automatic test_reset();
  @(posedge CLK);
  RST        <= 1'b1;
  i_req_full <= 1'b1;
  repeat (3) begin
    @(posedge CLK);
    check_equal(64'(o_valid), 64'(0), "o_valid during reset");
    check_equal(64'(o_req_valid), 64'(0), "o_req_valid during reset");
  end
  RST <= 1'b0;
  @(posedge CLK);
  check_equal(64'(o_valid), 64'(0), "o_valid after reset");
  check_equal(64'(o_req_valid), 64'(0), "o_req_valid after reset");
endtask

task automatic load_interleaved();
  clear_leaves();
  for (int l = 0; l < NLEAF; l++) begin
    for (int i = 0; i < 6; i++) add_rec(l, 32'(16 * i + 3 * l + 1));
  end
endtask

task automatic test_ascending();
  load_interleaved();
  run_merge(-1, 0);
endtask

task automatic test_tie();
  clear_leaves();
  add_rec(0, 5);
  add_rec(0, 20);
  add_rec(0, 40);
  add_rec(1, 5); // same keys as leaf 0
  add_rec(1, 20);
  add_rec(1, 40);
  add_rec(2, 7);
  add_rec(2, 21);
  add_rec(3, 8);
  add_rec(3, 43);
  run_merge(-1, 0);
endtask

task automatic test_backpressure();
  load_interleaved();
  run_merge(3, 30);
endtask

task automatic test_random();
  logic [31:0] k;
  int len;
  clear_leaves();
  for (int l = 0; l < NLEAF; l++) begin
    len = 2 + ($urandom % 10);
    k   = 0;
    for (int i = 0; i < len; i++) begin
      k = k + 4 + 4 * ($urandom % 64);
      add_rec(l, k | 32'(l)); // low bits keep leaves apart
    end
  end
  run_merge(-1, 0);
endtask

// ==== testbench/tb_merge_tree.sv ====
/*
  Testbench for the merge-sorter tree with four leaves.
  Holds the clock, reset, the DUT, a leaf model that answers leaf requests,
  an output monitor and the cycle timeout. Directed tests come from the
  included task file.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_merge_tree;
  import msort_pkg::*;

  localparam int W_LOG    = 2;
  localparam int FIFO_LOG = 2;
  localparam int NLEAF    = 2**W_LOG;
  localparam int DEPTH    = 2**FIFO_LOG; // priming records per leaf
  localparam int MAX_LEN  = 16;

  logic             CLK = 1'b0;
  logic             RST;
  rec_t             i_rec;
  logic             i_rec_valid;
  logic [W_LOG-1:0] i_rec_idx;
  logic             i_req_full;
  logic             i_out_full;
  logic [W_LOG-1:0] o_req_idx;
  logic             o_req_valid;
  rec_t             o_rec;
  logic             o_valid;

  rec_t             leaf_mem [NLEAF][MAX_LEN];
  int               leaf_len [NLEAF];
  int               leaf_pos [NLEAF];
  logic [W_LOG-1:0] pend_q [$]; // leaf requests not yet answered
  rec_t             exp_q [$];  // expected merged order
  logic             priming;
  int               out_cnt;
  int               cyc;
  int               cyc_limit;

  merge_tree #(.W_LOG(W_LOG), .FIFO_LOG(FIFO_LOG)) DUT (
    .CLK(CLK), .RST(RST),
    .i_rec(i_rec), .i_rec_valid(i_rec_valid), .i_rec_idx(i_rec_idx),
    .i_req_full(i_req_full), .i_out_full(i_out_full),
    .o_req_idx(o_req_idx), .o_req_valid(o_req_valid),
    .o_rec(o_rec), .o_valid(o_valid)
  );

  always #10 CLK = ~CLK;

  `include "tb_tasks.svh"

  // leaf model, answers one request per cycle in request order
  always @(posedge CLK) begin
    if (RST) begin
      pend_q.delete();
      i_rec_valid <= 1'b0;
    end else begin
      if (!priming) begin
        if (pend_q.size() > 0) begin
          i_rec_idx   <= pend_q[0];
          i_rec       <= next_leaf_rec(int'(pend_q[0]));
          i_rec_valid <= 1'b1;
          void'(pend_q.pop_front());
        end else begin
          i_rec_valid <= 1'b0;
        end
      end
      if (o_req_valid) pend_q.push_back(o_req_idx); // answered next edge at the earliest
    end
  end

  // output monitor, sentinel keys are skipped
  always @(posedge CLK) begin
    if (!RST && o_valid) begin
      if (i_out_full) begin
        fail_now("o_valid went high while i_out_full was held");
      end else if (o_rec.key != '1) begin
        if (out_cnt < exp_q.size()) check_equal(o_rec, exp_q[out_cnt], "merged record");
        out_cnt++; // extras show up in the record count
      end
    end
  end

  always @(posedge CLK) begin
    cyc++;
    if (cyc > cyc_limit) fail_now("Timeout: merged output did not complete in time");
  end

  initial begin
    void'($urandom(32'h67849c66));
    RST         = 1'b1;
    i_rec       = '0;
    i_rec_valid = 1'b0;
    i_rec_idx   = '0;
    i_req_full  = 1'b1;
    i_out_full  = 1'b0;
    priming     = 1'b1;
    out_cnt     = 0;
    cyc         = 0;
    cyc_limit   = 200;
    test_reset();
    test_ascending();
    test_tie();
    test_backpressure();
    test_random();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire
